/* all.f */
+incdir+hdl
hdl/cfg_dprio_pkg.sv
hdl/cfg_dprio_wr_if.sv
hdl/cfg_dprio_ctrl_reg_bit.sv
hdl/cfg_dprio_ctrl_reg_nbits.sv
hdl/cfg_dprio_host_port.sv
hdl/cfg_dprio_top.sv
testbench/cfg_dprio_checker.sv
testbench/cfg_dprio_tb.sv

/* Bender.yml */
package:
  name: cfg_dprio

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cfg_dprio_pkg.sv
      - hdl/cfg_dprio_wr_if.sv
      - hdl/cfg_dprio_ctrl_reg_bit.sv
      - hdl/cfg_dprio_ctrl_reg_nbits.sv
      - hdl/cfg_dprio_host_port.sv
      - hdl/cfg_dprio_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/cfg_dprio_checker.sv
      - testbench/cfg_dprio_tb.sv

/* testbench/cfg_dprio_tb.sv */
// One host and one transfer at a time; readback compares assume dprio_sel and gated_cram low
`timescale 1ns/1ps
`include "cfg_dprio_defs.svh"

module cfg_dprio_tb;

  localparam int W         = `CFG_DATA_WIDTH;
  localparam int AW        = `CFG_ADDR_WIDTH;
  localparam int N         = `CFG_NUM_REGS;
  localparam int CYC_LIMIT = 2000; // Roughly 3x the whole sequence

  logic              clk;
  logic              arst_n;
  logic              req;
  logic              wr;
  logic [AW-1:0]     addr;
  logic [W-1:0]      wdata;
  logic [W/8-1:0]    byte_en;
  logic              ack;
  logic              err;
  logic [W-1:0]      rdata;
  logic              csr_in;
  logic              hold_csr;
  logic              gated_cram;
  logic              dprio_sel;
  logic              pma_csr_test_dis;
  logic              csr_out;
  logic [N*W-1:0]    cfg_out;

  logic [W-1:0]      model_reg [N]; // Host written words
  logic              model_bcast;   // Broadcast control bit
  logic [N*W-1:0]    pattern;       // Chain load pattern
  int unsigned       err_cnt;
  int unsigned       cyc_cnt;

  cfg_dprio_top i_dut (.*);

  always #20 clk = ~clk; // 40 ns period

  //******************************
  // Reference model
  //******************************

  function automatic logic [AW-1:0] blk_addr(input logic [3:0] idx);
    return {`CFG_BLOCK_ID, idx};
  endfunction

  // Wrong block or an offset that is neither a register nor control
  function automatic logic addr_bad(input logic [AW-1:0] a);
    return (a[AW-1:4] != `CFG_BLOCK_ID) || (a[3:0] >= N && a[3:0] != `CFG_CTL_OFFSET);
  endfunction

  function automatic logic [W-1:0] model_read(input logic [AW-1:0] a);
    if (a[3:0] == `CFG_CTL_OFFSET)
      return W'(model_bcast);
    return model_reg[a[1:0]];
  endfunction

  function automatic logic [N*W-1:0] model_flat();
    logic [N*W-1:0] f;
    for (int k = 0; k < N; k++)
      f[k*W +: W] = model_reg[k]; // Reg k at 16k up
    return f;
  endfunction

  task automatic model_write(input logic [AW-1:0] a, input logic [W-1:0] d,
                             input logic [W/8-1:0] be);
    if (addr_bad(a))
      return;                                // No change on error
    if (a[3:0] == `CFG_CTL_OFFSET)
    begin
      if (be[0])
        model_bcast = d[0];
    end
    else
      for (int k = 0; k < N; k++)
        if (model_bcast || 4'(k) == a[3:0])  // Broadcast hits all
          for (int b = 0; b < W/8; b++)
            if (be[b])
              model_reg[k][b*8 +: 8] = d[b*8 +: 8];
  endtask

  //******************************
  // Host side and compare
  //******************************

  // Full four-phase transfer
  task automatic host_xfer(input logic is_wr, input logic [AW-1:0] a, input logic [W-1:0] d,
                           input logic [W/8-1:0] be, output logic [W-1:0] rd, output logic e);
    @(posedge clk);
    req     <= 1'b1;
    wr      <= is_wr;
    addr    <= a;
    wdata   <= d;
    byte_en <= be;
    @(posedge clk);
    while (!ack)
      @(posedge clk);
    rd = rdata;       // Valid with ack
    e  = err;
    req <= 1'b0;
    @(posedge clk);
    while (ack)       // New req only after ack low
      @(posedge clk);
  endtask

  task automatic compare(input string name, input logic [N*W-1:0] exp, input logic [N*W-1:0] act);
    assert (act === exp)
    else
    begin
      err_cnt++;
      $display("ERR %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  // One transfer checked for flag, data and outputs against the model
  task automatic access(input string name, input logic is_wr, input logic [AW-1:0] a,
                        input logic [W-1:0] d, input logic [W/8-1:0] be);
    logic [W-1:0] rd;
    logic         e;
    host_xfer(is_wr, a, d, be, rd, e);
    if (is_wr)
      model_write(a, d, be);
    compare({name, " err"}, addr_bad(a), e);
    if (!is_wr && !addr_bad(a))
      compare({name, " rdata"}, model_read(a), rd);
    compare({name, " cfg_out"}, model_flat(), cfg_out);
  endtask

  // Random bits into the chain
  task automatic shift_noise(input int n);
    for (int i = 0; i < n; i++)
    begin
      @(posedge clk);
      csr_in <= 1'($urandom);
    end
  endtask

  //******************************
  // Sequence
  //******************************

  initial
  begin
    void'($urandom(32'ha85a_b827)); // Seed once
    clk              = 1'b0;
    arst_n           = 1'b0;
    req              = 1'b0;
    wr               = 1'b0;
    addr             = '0;
    wdata            = '0;
    byte_en          = '0;
    csr_in           = 1'b0;
    hold_csr         = 1'b0;        // Chain runs from the start
    gated_cram       = 1'b0;
    dprio_sel        = 1'b0;
    pma_csr_test_dis = 1'b0;
    model_bcast      = 1'b0;
    err_cnt          = 0;
    cyc_cnt          = 0;
    for (int k = 0; k < N; k++)
      model_reg[k] = '0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;

    // Single register writes with random byte enables
    for (int k = 0; k < N; k++)
      for (int n = 0; n < 3; n++)
      begin
        access("single_wr", 1'b1, blk_addr(4'(k)), W'($urandom), 2'($urandom));
        access("single_rd", 1'b0, blk_addr(4'(k)), '0, 2'b00);
      end

    // Broadcast on and kept by a byte 1 write
    access("bcast_on", 1'b1, blk_addr(`CFG_CTL_OFFSET), 16'h0001, 2'b01);
    access("bcast_hi", 1'b1, blk_addr(`CFG_CTL_OFFSET), 16'h0000, 2'b10);
    access("bcast_rd", 1'b0, blk_addr(`CFG_CTL_OFFSET), '0, 2'b00);
    for (int k = 0; k < N; k++)
      access("bcast_wr", 1'b1, blk_addr(4'(k)), W'($urandom), 2'($urandom));
    access("bcast_off", 1'b1, blk_addr(`CFG_CTL_OFFSET), 16'h0000, 2'b01);
    access("unicast_wr", 1'b1, blk_addr(4'd2), W'($urandom), 2'b11);
    for (int k = 0; k < N; k++)
      access("unicast_rd", 1'b0, blk_addr(4'(k)), '0, 2'b00);

    // Bad addresses get ack with err and change nothing
    access("bad_blk_wr", 1'b1, {`CFG_BLOCK_ID ^ 12'h001, 4'h1}, W'($urandom), 2'b11);
    access("bad_off_wr", 1'b1, blk_addr(4'h7), W'($urandom), 2'b11);
    access("bad_blk_rd", 1'b0, {`CFG_BLOCK_ID ^ 12'h800, 4'h0}, '0, 2'b00);
    access("bad_off_rd", 1'b0, blk_addr(4'hE), '0, 2'b00);

    // Chain load puts the first bit in at bit 63
    pattern = {$urandom, $urandom};
    shift_noise(N*W);
    for (int i = N*W-1; i >= 0; i--)
    begin
      @(posedge clk);
      csr_in <= pattern[i];
    end
    @(posedge clk);
    hold_csr  <= 1'b1;
    dprio_sel <= 1'b1;
    @(posedge clk);
    compare("chain_load", pattern, cfg_out);

    // Test disable then gating
    pma_csr_test_dis <= 1'b1;
    @(posedge clk);
    compare("test_dis", model_flat(), cfg_out);
    gated_cram <= 1'b1;
    @(posedge clk);
    compare("gated", '0, cfg_out);
    gated_cram       <= 1'b0;
    dprio_sel        <= 1'b0;
    pma_csr_test_dis <= 1'b0;
    hold_csr         <= 1'b0;
    shift_noise(N*W + 16);          // Delay check restarts after hold
    for (int k = 0; k < N; k++)
      access("final_rd", 1'b0, blk_addr(4'(k)), '0, 2'b00);

    repeat (2) @(posedge clk);
    $display("Errors: %0d testbench checks, %0d assertion failures",
             err_cnt, i_dut.i_checker.fire_cnt);
    if (err_cnt == 0 && i_dut.i_checker.fire_cnt == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Run limit
  always @(posedge clk)
  begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt == CYC_LIMIT)
    begin
      $display("Timeout: run did not finish within %0d cycles", CYC_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule

/* testbench/cfg_dprio_checker.sv */
// Bound into cfg_dprio_top; chain delay check needs a known csr_in and restarts after any hold_csr
`timescale 1ns/1ps
`include "cfg_dprio_defs.svh"

module cfg_dprio_checker
(
  input logic                                     clk,
  input logic                                     arst_n,
  input logic                                     req,
  input logic                                     ack,
  input logic                                     err,
  input logic                                     csr_in,
  input logic                                     hold_csr,
  input logic                                     csr_out,
  input logic                                     gated_cram,
  input logic [`CFG_NUM_REGS*`CFG_DATA_WIDTH-1:0] cfg_out
);

  localparam int CHAIN_LEN = `CFG_NUM_REGS*`CFG_DATA_WIDTH; // Flops from csr_in to csr_out

  int unsigned fire_cnt = 0; // Failed assertions so far
  int unsigned free_run;     // Shift edges since reset or hold

  // Counts shifting edges, saturates at chain length
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      free_run <= 0;
    else if (hold_csr)
      free_run <= 0;                 // Chain frozen
    else if (free_run < CHAIN_LEN)
      free_run <= free_run + 1;
  end

  //******************************
  // Handshake
  //******************************

  a_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(ack) |-> $past(req))
  else
  begin
    fire_cnt++;
    $error("ack rose while req was low");
  end

  a_ack_drop: assert property (@(posedge clk) disable iff (!arst_n)
    (ack && !req) |=> !ack)       // One cycle after req low
  else
  begin
    fire_cnt++;
    $error("ack still high one cycle after req dropped");
  end

  a_err_ack: assert property (@(posedge clk) disable iff (!arst_n)
    err |-> ack)
  else
  begin
    fire_cnt++;
    $error("err high without ack");
  end

  //******************************
  // Chain and gating
  //******************************

  a_chain_delay: assert property (@(posedge clk) disable iff (!arst_n)
    (free_run >= CHAIN_LEN) |-> (csr_out == $past(csr_in, CHAIN_LEN)))
  else
  begin
    fire_cnt++;
    $error("csr_out does not follow csr_in after the full chain delay");
  end

  a_gated: assert property (@(posedge clk) disable iff (!arst_n)
    gated_cram |-> (cfg_out == '0))
  else
  begin
    fire_cnt++;
    $error("cfg_out not zero while gated_cram is high");
  end

endmodule

bind cfg_dprio_top cfg_dprio_checker i_checker
(
  .clk        (clk),
  .arst_n     (arst_n),
  .req        (req),
  .ack        (ack),
  .err        (err),
  .csr_in     (csr_in),
  .hold_csr   (hold_csr),
  .csr_out    (csr_out),
  .gated_cram (gated_cram),
  .cfg_out    (cfg_out)
);

/* hdl/cfg_dprio_top.sv */
// Single channel only; csr_out lags csr_in by NUM_REGS*DATA_WIDTH cycles while hold_csr is low
`timescale 1ns/1ps
`include "cfg_dprio_defs.svh"

module cfg_dprio_top
(
  input  logic                                     clk,              // Core clock
  input  logic                                     arst_n,           // Async reset, active low
  // Host port
  input  logic                                     req,              // Four-phase request
  input  logic                                     wr,               // 1 = write
  input  logic [`CFG_ADDR_WIDTH-1:0]               addr,             // Block ID and offset
  input  logic [`CFG_DATA_WIDTH-1:0]               wdata,            // Write data
  input  logic [`CFG_DATA_WIDTH/8-1:0]             byte_en,          // Byte enables
  output logic                                     ack,              // Four-phase ack
  output logic                                     err,              // Bad address
  output logic [`CFG_DATA_WIDTH-1:0]               rdata,            // Read data
  // Test controls
  input  logic                                     csr_in,           // Chain in
  input  logic                                     hold_csr,         // Freeze chain
  input  logic                                     gated_cram,       // Force cfg_out low
  input  logic                                     dprio_sel,        // CSR on cfg_out
  input  logic                                     pma_csr_test_dis, // Block CSR select
  output logic                                     csr_out,          // Chain out
  // Config bits, register k at 16k+15:16k
  output logic [`CFG_NUM_REGS*`CFG_DATA_WIDTH-1:0] cfg_out
);

  logic [`CFG_NUM_REGS:0] chain; // Chain taps between registers

  cfg_dprio_wr_if wr_bus ();

  //******************************
  // Host port
  //******************************

  cfg_dprio_host_port i_host_port
  (
    .clk     (clk),
    .arst_n  (arst_n),
    .req     (req),
    .wr      (wr),
    .addr    (addr),
    .wdata   (wdata),
    .byte_en (byte_en),
    .ack     (ack),
    .err     (err),
    .rdata   (rdata),
    .wr_bus  (wr_bus.source),
    .reg_out (cfg_out)      // Readback of live outputs
  );

  //******************************
  // Register bank
  //******************************

  assign chain[0] = csr_in;
  assign csr_out  = chain[`CFG_NUM_REGS];

  generate
    genvar k;
    for (k = 0; k < `CFG_NUM_REGS; k++)
    begin : g_reg
      cfg_dprio_ctrl_reg_nbits i_reg
      (
        .clk              (clk),
        .arst_n           (arst_n),
        .wr               (wr_bus.sink),
        .target_idx       (cfg_dprio_pkg::cfg_reg_idx_t'(k)), // Own offset
        .csr_in           (chain[k]),
        .hold_csr         (hold_csr),
        .gated_cram       (gated_cram),
        .dprio_sel        (dprio_sel),
        .pma_csr_test_dis (pma_csr_test_dis),
        .sig_out          (cfg_out[k*`CFG_DATA_WIDTH +: `CFG_DATA_WIDTH]),
        .csr_out          (chain[k+1])                        // Next register
      );
    end
  endgenerate

endmodule

/* hdl/cfg_dprio_host_port.sv */
// Host must hold addr, wr, wdata and byte_en stable from req high until ack; req is in clk domain
`timescale 1ns/1ps
`include "cfg_dprio_defs.svh"

module cfg_dprio_host_port
(
  input  logic                                     clk,     // Core clock
  input  logic                                     arst_n,  // Async reset, active low
  input  logic                                     req,     // Host request
  input  logic                                     wr,      // 1 = write, 0 = read
  input  logic [`CFG_ADDR_WIDTH-1:0]               addr,    // Block ID and offset
  input  logic [`CFG_DATA_WIDTH-1:0]               wdata,   // Write data
  input  logic [`CFG_DATA_WIDTH/8-1:0]             byte_en, // Byte enables
  output logic                                     ack,     // Handshake ack
  output logic                                     err,     // Bad address, valid with ack
  output logic [`CFG_DATA_WIDTH-1:0]               rdata,   // Read data, valid with ack
  cfg_dprio_wr_if.source                           wr_bus,  // To the register bank
  input  logic [`CFG_NUM_REGS*`CFG_DATA_WIDTH-1:0] reg_out  // Register outputs, readback
);

  localparam logic [1:0] ST_IDLE   = 2'd0; // Wait for req
  localparam logic [1:0] ST_STROBE = 2'd1; // Write pulse cycle
  localparam logic [1:0] ST_ACK    = 2'd2; // Hold ack until req drops

  cfg_dprio_pkg::cfg_addr_u   addr_u;    // Decoded host address
  logic                       blk_ok;    // Block ID matches
  logic                       is_reg;    // Offset names a register
  logic                       is_ctl;    // Offset names control reg
  logic [1:0]                 state;
  logic                       strobe_q;  // Register write pulse
  logic                       ctl_wr_q;  // Control write pending
  logic                       err_q;     // Address check result
  logic                       bcast_q;   // Broadcast control bit
  logic [`CFG_DATA_WIDTH-1:0] rdata_sel; // Readback mux out

  //******************************
  // Address decode
  //******************************

  assign addr_u = addr;
  assign blk_ok = (addr_u.fields.block_id == `CFG_BLOCK_ID);
  assign is_reg = (addr_u.fields.reg_idx < `CFG_NUM_REGS);
  assign is_ctl = (addr_u.fields.reg_idx == `CFG_CTL_OFFSET);

  // Readback, zero on bad address
  always_comb
  begin
    rdata_sel = '0;
    if (blk_ok && is_ctl)
      rdata_sel = {{(`CFG_DATA_WIDTH-1){1'b0}}, bcast_q};
    else if (blk_ok)
      for (int k = 0; k < `CFG_NUM_REGS; k++)
        if (addr_u.fields.reg_idx == k)
          rdata_sel = reg_out[k*`CFG_DATA_WIDTH +: `CFG_DATA_WIDTH];
  end

  //******************************
  // Handshake sequencer
  //******************************

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state    <= ST_IDLE;
      strobe_q <= 1'b0;
      ctl_wr_q <= 1'b0;
      err_q    <= 1'b0;
      ack      <= 1'b0;
      err      <= 1'b0;
      rdata    <= '0;
      bcast_q  <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (req)                                  // Address checked here
          begin
            state    <= ST_STROBE;
            strobe_q <= wr && blk_ok && is_reg;     // Register writes only
            ctl_wr_q <= wr && blk_ok && is_ctl;
            err_q    <= !blk_ok || !(is_reg || is_ctl);
          end
        end
        ST_STROBE:
        begin
          state    <= ST_ACK;
          strobe_q <= 1'b0;                         // Single pulse
          ctl_wr_q <= 1'b0;
          ack      <= 1'b1;
          err      <= err_q;
          rdata    <= rdata_sel;                    // Held through ack
          if (ctl_wr_q && byte_en[0])
            bcast_q <= wdata[0];                    // Broadcast bit lives in byte 0
        end
        ST_ACK:
        begin
          if (!req)                                 // Host done
          begin
            state <= ST_IDLE;
            ack   <= 1'b0;
            err   <= 1'b0;
          end
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  //******************************
  // Write bus
  //******************************

  // Payload comes straight from the held host inputs
  assign wr_bus.write        = strobe_q;
  assign wr_bus.reg_addr     = addr_u;
  assign wr_bus.writedata    = wdata;
  assign wr_bus.byte_en      = byte_en;
  assign wr_bus.broadcast_en = bcast_q; // Level

endmodule

/* hdl/cfg_dprio_ctrl_reg_nbits.sv */
// Width fixed by CFG_DATA_WIDTH, which must be a multiple of 8; bit 0 is the chain entry
`timescale 1ns/1ps
`include "cfg_dprio_defs.svh"

module cfg_dprio_ctrl_reg_nbits
(
  input  logic                        clk,              // Core clock
  input  logic                        arst_n,           // Async reset, active low
  cfg_dprio_wr_if.sink                wr,               // Write bus from host port
  input  cfg_dprio_pkg::cfg_reg_idx_t target_idx,       // Own offset
  input  logic                        csr_in,           // Chain in, to bit 0
  input  logic                        hold_csr,         // Freeze chain
  input  logic                        gated_cram,       // Force outputs low
  input  logic                        dprio_sel,        // CSR on outputs
  input  logic                        pma_csr_test_dis, // Block CSR select
  output logic [`CFG_DATA_WIDTH-1:0]  sig_out,          // Config bits
  output logic                        csr_out           // Chain out, from top bit
);

  cfg_dprio_pkg::cfg_addr_u    target_addr; // Full address of this register
  logic                        hit;         // Write addressed here
  logic [`CFG_DATA_WIDTH-1:0]  bit_en;      // Per bit load enable
  logic [`CFG_DATA_WIDTH:0]    chain;       // Serial path, one extra tap

  //******************************
  // Address match
  //******************************

  // Block ID above own offset
  assign target_addr.raw = {`CFG_BLOCK_ID, target_idx};

  // Broadcast catches every strobe
  assign hit = wr.write && (wr.broadcast_en || (wr.reg_addr.raw == target_addr.raw));

  // Byte enable fans out to its 8 bits
  generate
    genvar b;
    for (b = 0; b < `CFG_DATA_WIDTH; b++)
    begin : g_bit_en
      assign bit_en[b] = hit && wr.byte_en[b/8];
    end
  endgenerate

  //******************************
  // Bit cells
  //******************************

  assign chain[0] = csr_in; // Chain entry

  generate
    genvar j;
    for (j = 0; j < `CFG_DATA_WIDTH; j++)
    begin : g_bit
      cfg_dprio_ctrl_reg_bit i_bit
      (
        .clk              (clk),
        .arst_n           (arst_n),
        .dprio_in         (wr.writedata[j]),
        .bit_en           (bit_en[j]),
        .csr_in           (chain[j]),       // From bit below
        .hold_csr         (hold_csr),
        .dprio_sel        (dprio_sel),
        .gated_cram       (gated_cram),
        .pma_csr_test_dis (pma_csr_test_dis),
        .sig_out          (sig_out[j]),
        .csr_out          (chain[j+1])      // To bit above
      );
    end
  endgenerate

  assign csr_out = chain[`CFG_DATA_WIDTH]; // Top bit leaves

endmodule

/* hdl/cfg_dprio_ctrl_reg_bit.sv */
// Output select is combinational; gated_cram overrides both the CSR and the host value
`timescale 1ns/1ps

module cfg_dprio_ctrl_reg_bit
(
  input  logic clk,              // Core clock
  input  logic arst_n,           // Async reset, active low
  input  logic dprio_in,         // Host write value
  input  logic bit_en,           // Load dprio_in this cycle
  input  logic csr_in,           // Serial chain in
  input  logic hold_csr,         // Freeze the chain
  input  logic dprio_sel,        // 1 = CSR value on output
  input  logic gated_cram,       // Force output low
  input  logic pma_csr_test_dis, // Blocks CSR select
  output logic sig_out,          // Config bit to channel
  output logic csr_out           // Serial chain out
);

  logic dprio_q; // Host written value
  logic csr_q;   // Scan chain stage
  logic use_csr; // CSR value selected

  //******************************
  // Storage
  //******************************

  // Host side value, loads on write hit
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      dprio_q <= 1'b0;
    else if (bit_en)
      dprio_q <= dprio_in;
  end

  // One chain stage per bit
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      csr_q <= 1'b0;
    else if (!hold_csr)
      csr_q <= csr_in; // Shift
  end

  assign csr_out = csr_q;

  //******************************
  // Output select
  //******************************

  // Test disable wins over dprio_sel
  assign use_csr = dprio_sel && !pma_csr_test_dis;

  always_comb
  begin
    if (gated_cram)
      sig_out = 1'b0;            // Gated off
    else if (use_csr)
      sig_out = csr_q;           // Scan value
    else
      sig_out = dprio_q;         // Host value
  end

endmodule

/* hdl/cfg_dprio_wr_if.sv */
// Payload is only valid while write is high; broadcast_en is a level and always valid
`timescale 1ns/1ps
`include "cfg_dprio_defs.svh"

interface cfg_dprio_wr_if;

  //******************************
  // Write bus signals
  //******************************

  logic                          write;        // One-cycle strobe
  cfg_dprio_pkg::cfg_addr_u      reg_addr;     // Target address
  logic [`CFG_DATA_WIDTH-1:0]    writedata;    // Data to load
  logic [`CFG_DATA_WIDTH/8-1:0]  byte_en;      // One bit per byte
  logic                          broadcast_en; // Write all registers

  // Host port side
  modport source
  (
    output write,
    output reg_addr,
    output writedata,
    output byte_en,
    output broadcast_en
  );

  // Register side
  modport sink
  (
    input write,
    input reg_addr,
    input writedata,
    input byte_en,
    input broadcast_en
  );

endinterface

/* hdl/cfg_dprio_pkg.sv */
// Address split assumes the offset sits in the low 4 bits, block ID in all bits above it
`include "cfg_dprio_defs.svh"

package cfg_dprio_pkg;

  //******************************
  // Register offset
  //******************************

  // Low nibble of the host address
  typedef logic [3:0] cfg_reg_idx_t;

  // Field view of one address word
  typedef struct packed
  {
    logic [`CFG_ADDR_WIDTH-$bits(cfg_reg_idx_t)-1:0] block_id; // Upper bits, block select
    cfg_reg_idx_t                                    reg_idx;  // Register offset
  } cfg_addr_fields_t;

  //******************************
  // Address word, two views
  //******************************

  // Raw view for full compare in the register,
  // field view for block check and readback in the host port
  typedef union packed
  {
    logic [`CFG_ADDR_WIDTH-1:0] raw;    // Whole address
    cfg_addr_fields_t           fields; // block_id / reg_idx
  } cfg_addr_u;

endpackage

/* hdl/cfg_dprio_defs.svh */
// Widths and IDs are fixed here; the block answers to one block ID and one channel only
`ifndef CFG_DPRIO_DEFS_SVH
`define CFG_DPRIO_DEFS_SVH

//******************************
// Data path sizes
//******************************

// Width of one control register
`define CFG_DATA_WIDTH 16
// Host address width, block ID plus offset
`define CFG_ADDR_WIDTH 16
// Control registers in the bank
`define CFG_NUM_REGS 4

//******************************
// Address map
//******************************

// Upper address bits this block decodes
`define CFG_BLOCK_ID 12'h3A5
// Offset of broadcast control reg
`define CFG_CTL_OFFSET 4'hF

`endif
